//--- runSim.sh
#!/bin/sh
# build and run the menu overlay testbench with Verilator
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tbTetrisMenu -Mdir "$buildDir" -f sources.f; then
    echo "verilator build failed"
    exit 1
fi

"./$buildDir/VtbTetrisMenu" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides, a timeout also ends with a clean exit
if grep -qx "ALL TESTS PASSED" "$logFile"; then
    exit 0
fi
echo "pass message not found in $logFile"
exit 1

//--- sources.f
src/oledPkg.sv
src/menuPkg.sv
src/buttonPulse.sv
src/menuCursor.sv
src/menuRenderer.sv
src/tetrisMenuOverlay.sv
testbench/tbTetrisMenu.sv

//--- src/buttonPulse.sv
`timescale 1ns/10ps
`default_nettype none

// one push button in, one single-cycle pulse per press out
module buttonPulse (
    input  logic clk,
    input  logic arstN,
    input  logic btn,         // raw level from the pad
    output logic pressPulse
);

    localparam int cntBits = $clog2(menuPkg::debounceCycles + 1);
    localparam logic [cntBits-1:0] cntFull = cntBits'(menuPkg::debounceCycles);

    logic               syncA;
    logic               syncB;
    logic [cntBits-1:0] holdCnt;
    logic               stable;
    logic               stableD;

    // two flop synchroniser
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            syncA <= 1'b0;
            syncB <= 1'b0;
        end else begin
            syncA <= btn;
            syncB <= syncA;
        end
    end

    // counts high cycles, saturates at full, drops to zero on any low
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            holdCnt <= '0;
        end else if (!syncB) begin
            holdCnt <= '0;
        end else if (holdCnt != cntFull) begin
            holdCnt <= holdCnt + 1'b1;
        end
    end

    assign stable = (holdCnt == cntFull);

    // rising edge of the debounced level
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stableD    <= 1'b0;
            pressPulse <= 1'b0;
        end else begin
            stableD    <= stable;
            pressPulse <= stable && !stableD;
        end
    end

    // a held button must never repeat the pulse
    pulseSingle: assert property (@(posedge clk) disable iff (!arstN)
        pressPulse |=> !pressPulse);

endmodule

`default_nettype wire

//--- src/menuCursor.sv
`timescale 1ns/10ps
`default_nettype none

// cursor of the yes/no restart prompt plus the confirm decoder
module menuCursor (
    input  logic             clk,
    input  logic             arstN,
    input  logic             leftPulse,
    input  logic             rightPulse,
    input  logic             confirmPulse,
    input  logic             pause,
    output menuPkg::menuSelE cursor,
    output logic             restartReq,
    output logic             quitReq
);

    // one action per cycle, confirm first, then left over right
    typedef enum logic [1:0] {
        actHold,
        actLeft,
        actRight,
        actConfirm
    } cursorActE;

    cursorActE        action;
    menuPkg::menuSelE leftOf;
    menuPkg::menuSelE rightOf;

    always_comb begin
        if (pause) begin
            action = actHold;           // menu frozen while paused
        end else if (confirmPulse) begin
            action = actConfirm;
        end else if (leftPulse) begin
            action = actLeft;
        end else if (rightPulse) begin
            action = actRight;
        end else begin
            action = actHold;
        end
    end

    // saturating neighbours
    always_comb begin
        case (cursor)
            menuPkg::selYes: begin
                leftOf  = menuPkg::selNone;
                rightOf = menuPkg::selNo;
            end
            menuPkg::selNo: begin
                leftOf  = menuPkg::selYes;
                rightOf = menuPkg::selNo;
            end
            default: begin
                leftOf  = menuPkg::selNone;
                rightOf = menuPkg::selYes;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cursor     <= menuPkg::selNo;
            restartReq <= 1'b0;
            quitReq    <= 1'b0;
        end else begin
            restartReq <= (action == actConfirm) && (cursor == menuPkg::selYes);
            quitReq    <= (action == actConfirm) && (cursor == menuPkg::selNo);
            case (action)
                actLeft:    cursor <= leftOf;
                actRight:   cursor <= rightOf;
                actConfirm: cursor <= menuPkg::selNone;  // back to no highlight
                default:    cursor <= cursor;
            endcase
        end
    end

    cursorLegal: assert property (@(posedge clk) disable iff (!arstN)
        cursor inside {menuPkg::selNone, menuPkg::selYes, menuPkg::selNo});

    reqExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(restartReq && quitReq));

endmodule

`default_nettype wire

//--- src/menuPkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// restart prompt cursor and button handling
////////////////////////////////////////////////////////////////////////////

package menuPkg;

    // cursor position on the restart prompt
    // encoding follows the overlay select of the display mux
    typedef enum logic [1:0] {
        selNone = 2'd1,  // no highlight
        selYes  = 2'd2,  // box over YES
        selNo   = 2'd3   // box over NO, reset value
    } menuSelE;

    // left walks towards selNone, right towards selNo
    // both ends saturate

    ////////////////////////////////////////////////////////////////////////////
    // push buttons
    ////////////////////////////////////////////////////////////////////////////

    // cycles of a steady high level before a press counts
    localparam int debounceCycles = 4;

endpackage

`default_nettype wire

//--- src/menuRenderer.sv
`timescale 1ns/10ps
`default_nettype none

// pixel index to colour for the pause banner and the restart prompt
module menuRenderer (
    input  logic                                  clk,
    input  logic                                  arstN,
    input  logic [oledPkg::pixelIndexBits-1:0]    pixelIndex,
    input  logic                                  pause,
    input  menuPkg::menuSelE                      cursor,
    output logic [15:0]                           oledData
);

    localparam int cb = oledPkg::coordBits;

    logic [cb-1:0]    rowIdx;
    logic [cb-1:0]    colIdx;
    logic [cb-1:0]    xQ;
    logic [cb-1:0]    yQ;
    logic             pauseQ;
    menuPkg::menuSelE cursorQ;
    int               px;
    int               py;
    logic             pauseText;
    logic             overText;
    logic             restartText;
    logic             yesText;
    logic             noText;
    logic             arrow1;
    logic             arrow2;
    logic             box1;
    logic             box2;
    logic             lit;

    ////////////////////////////////////////////////////////////////////////////
    // stage 1 splits and rotates
    ////////////////////////////////////////////////////////////////////////////

    assign rowIdx = cb'(pixelIndex / oledPkg::panelWidth);
    assign colIdx = cb'(pixelIndex % oledPkg::panelWidth);

    always_ff @(posedge clk) begin
        xQ <= cb'(oledPkg::panelHeight - 1) - rowIdx;  // panel mounted rotated
        yQ <= colIdx;
    end

    // pause and cursor travel with their pixel
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pauseQ  <= 1'b0;
            cursorQ <= menuPkg::selNo;
        end else begin
            pauseQ  <= pause;
            cursorQ <= cursor;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // 5x7 glyphs with dx/dy relative to the top left of the cell
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic span(input int v, input int lo, input int hi);
        return (v >= lo) && (v <= hi);
    endfunction

    function automatic logic glyphG(input int dx, input int dy);
        return (dx == 0 && span(dy, 1, 6)) || ((dy == 0 || dy == 6) && span(dx, 1, 2))
            || ((dy == 1 || dy == 5) && dx == 3) || (dx == 4 && span(dy, 5, 6));
    endfunction

    function automatic logic glyphA(input int dx, input int dy);
        return (dx == 4 && span(dy, 0, 6)) || (dx == 0 && span(dy, 3, 6))
            || (dy == 3 && span(dx, 0, 4))
            || (dx == 3 && dy == 0) || (dx == 2 && dy == 1) || (dx == 1 && dy == 2);
    endfunction

    function automatic logic glyphM(input int dx, input int dy);
        return (span(dy, 0, 6) && (dx == 0 || dx == 4))
            || (dy == 1 && (dx == 1 || dx == 3)) || (dy == 2 && dx == 2);
    endfunction

    function automatic logic glyphE(input int dx, input int dy);
        return span(dy, 0, 6)
            && (dx == 0 || (span(dx, 1, 3) && (dy == 0 || dy == 3 || dy == 6)));
    endfunction

    function automatic logic glyphP(input int dx, input int dy);
        return (dx == 0 && span(dy, 0, 6)) || (span(dx, 1, 2) && (dy == 0 || dy == 3))
            || (dx == 3 && span(dy, 1, 2));
    endfunction

    function automatic logic glyphU(input int dx, input int dy);
        return ((dx == 0 || dx == 3) && span(dy, 0, 5)) || (span(dx, 1, 2) && dy == 6);
    endfunction

    function automatic logic glyphS(input int dx, input int dy);
        return (span(dx, 0, 3) && (dy == 0 || dy == 3 || dy == 6))
            || (dx == 0 && span(dy, 1, 2)) || (dx == 3 && span(dy, 4, 5));
    endfunction

    function automatic logic glyphD(input int dx, input int dy);
        return (dx == 0 && span(dy, 0, 6)) || (span(dx, 1, 2) && (dy == 0 || dy == 6))
            || (dx == 3 && span(dy, 1, 5));
    endfunction

    function automatic logic glyphO(input int dx, input int dy);
        return ((dx == 0 || dx == 4) && span(dy, 1, 5))
            || (span(dx, 1, 3) && (dy == 0 || dy == 6));
    endfunction

    function automatic logic glyphV(input int dx, input int dy);
        return ((dx == 0 || dx == 4) && span(dy, 0, 4))
            || ((dx == 1 || dx == 3) && dy == 5) || (dx == 2 && dy == 6);
    endfunction

    function automatic logic glyphR(input int dx, input int dy);
        return (dx == 0 && span(dy, 0, 6)) || (span(dx, 0, 2) && (dy == 0 || dy == 3))
            || (dx == 2 && span(dy, 1, 2))
            || (dx == 1 && dy == 4) || (dx == 2 && dy == 5) || (dx == 3 && dy == 6);
    endfunction

    function automatic logic glyphT(input int dx, input int dy);
        return (span(dx, 0, 4) && dy == 0) || (dx == 2 && span(dy, 0, 6));
    endfunction

    function automatic logic glyphQuery(input int dx, input int dy);
        return (dx == 0 && (dy == 0 || dy == 1 || dy == 3 || dy == 4 || dy == 6))
            || (span(dx, 1, 3) && (dy == 0 || dy == 3)) || (dx == 3 && span(dy, 1, 2));
    endfunction

    function automatic logic glyphBang(input int dx, input int dy);
        return dx == 0 && (span(dy, 0, 4) || dy == 6);
    endfunction

    function automatic logic glyphY(input int dx, input int dy);
        return (dy == 2 && span(dx, 0, 4)) || (span(dy, 0, 1) && (dx == 0 || dx == 4))
            || (dx == 2 && span(dy, 3, 6));
    endfunction

    function automatic logic glyphN(input int dx, input int dy);
        return ((dx == 0 || dx == 4) && span(dy, 0, 6))
            || (dx == 1 && dy == 2) || (dx == 2 && dy == 3) || (dx == 3 && dy == 4);
    endfunction

    // small right pointing triangle 4 wide and 5 tall
    function automatic logic glyphArrow(input int dx, input int dy);
        return (dx == 0 && span(dy, 0, 4)) || (dx == 1 && (dy == 0 || dy == 4))
            || (dx == 2 && (dy == 1 || dy == 3)) || (dx == 3 && dy == 2);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stage 2 hit test and colour
    ////////////////////////////////////////////////////////////////////////////

    assign px = int'(xQ);
    assign py = int'(yQ);

    assign pauseText = glyphG(px - 4, py - 45) || glyphA(px - 9, py - 45)
        || glyphM(px - 15, py - 45) || glyphE(px - 21, py - 45)
        || glyphP(px - 28, py - 45) || glyphA(px - 33, py - 45)
        || glyphU(px - 39, py - 45) || glyphS(px - 44, py - 45)
        || glyphE(px - 49, py - 45) || glyphD(px - 54, py - 45);

    assign overText = glyphG(px - 7, py - 17) || glyphA(px - 13, py - 17)
        || glyphM(px - 19, py - 17) || glyphE(px - 25, py - 17)
        || glyphO(px - 32, py - 17) || glyphV(px - 38, py - 17)
        || glyphE(px - 44, py - 17) || glyphR(px - 49, py - 17)
        || glyphBang(px - 55, py - 17);

    assign restartText = glyphR(px - 10, py - 41) || glyphE(px - 15, py - 41)
        || glyphS(px - 20, py - 41) || glyphT(px - 25, py - 41)
        || glyphA(px - 31, py - 41) || glyphR(px - 37, py - 41)
        || glyphT(px - 42, py - 41) || glyphQuery(px - 50, py - 41);

    assign yesText = glyphY(px - 27, py - 57) || glyphE(px - 33, py - 57)
        || glyphS(px - 38, py - 57);
    assign noText = glyphN(px - 27, py - 72) || glyphO(px - 33, py - 72);

    assign arrow1 = glyphArrow(px - 21, py - 58);
    assign arrow2 = glyphArrow(px - 21, py - 73);

    // inverted highlight with text and arrow cut out of the band
    assign box1 = span(py, 55, 65) && !yesText && !arrow1;
    assign box2 = span(py, 70, 80) && !noText && !arrow2;

    always_comb begin
        if (pauseQ) begin
            lit = pauseText;
        end else begin
            case (cursorQ)
                menuPkg::selYes: lit = overText || restartText || box1 || noText;
                menuPkg::selNo:  lit = overText || restartText || yesText || box2;
                default:         lit = overText || restartText || yesText || noText;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            oledData <= oledPkg::colourBlack;
        end else begin
            oledData <= lit ? oledPkg::colourWhite : oledPkg::colourBlack;
        end
    end

    // cursor only matters while the prompt is shown
    cursorValid: assert property (@(posedge clk) disable iff (!arstN)
        !pause |-> cursor inside {menuPkg::selNone, menuPkg::selYes, menuPkg::selNo});

endmodule

`default_nettype wire

//--- src/oledPkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// panel geometry and pixel addressing
////////////////////////////////////////////////////////////////////////////

package oledPkg;

    // panel as mounted, before the rotation
    localparam int panelWidth = 96;      // columns
    localparam int panelHeight = 64;     // rows

    // driver scans index = row * panelWidth + col
    localparam int pixelIndexBits = 13;

    // rotated x runs 0..63, rotated y runs 0..95
    localparam int coordBits = 7;

    ////////////////////////////////////////////////////////////////////////////
    // RGB565 colours
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [15:0] colourWhite = 16'hFFFF;
    localparam logic [15:0] colourBlack = 16'h0000;

    // index in, colour out, in clock cycles
    // one stage for the rotation, one for the glyph lookup
    localparam int renderLatency = 2;

endpackage

`default_nettype wire

//--- src/tetrisMenuOverlay.sv
`timescale 1ns/10ps
`default_nettype none

// menu overlay of the game, buttons in, colour and requests out
module tetrisMenuOverlay (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic                               btnL,
    input  logic                               btnR,
    input  logic                               btnC,
    input  logic                               pause,
    input  logic [oledPkg::pixelIndexBits-1:0] pixelIndex,
    output logic [15:0]                        oledData,
    output logic                               restartReq,
    output logic                               quitReq
);

    logic             leftPulse;
    logic             rightPulse;
    logic             confirmPulse;
    menuPkg::menuSelE cursor;

    ////////////////////////////////////////////////////////////////////////////
    // buttons
    ////////////////////////////////////////////////////////////////////////////

    buttonPulse uPulseL (
        .clk        (clk),
        .arstN      (arstN),
        .btn        (btnL),
        .pressPulse (leftPulse)
    );

    buttonPulse uPulseR (
        .clk        (clk),
        .arstN      (arstN),
        .btn        (btnR),
        .pressPulse (rightPulse)
    );

    buttonPulse uPulseC (
        .clk        (clk),
        .arstN      (arstN),
        .btn        (btnC),
        .pressPulse (confirmPulse)   // centre button confirms
    );

    ////////////////////////////////////////////////////////////////////////////
    // cursor and display
    ////////////////////////////////////////////////////////////////////////////

    menuCursor uCursor (
        .clk          (clk),
        .arstN        (arstN),
        .leftPulse    (leftPulse),
        .rightPulse   (rightPulse),
        .confirmPulse (confirmPulse),
        .pause        (pause),
        .cursor       (cursor),
        .restartReq   (restartReq),
        .quitReq      (quitReq)
    );

    menuRenderer uRenderer (
        .clk        (clk),
        .arstN      (arstN),
        .pixelIndex (pixelIndex),
        .pause      (pause),
        .cursor     (cursor),
        .oledData   (oledData)
    );

endmodule

`default_nettype wire

//--- testbench/tbTetrisMenu.sv
`timescale 1ns/10ps
`default_nettype none

// random button and pixel stimulus for the menu overlay checked against a cursor model
module tbTetrisMenu;

    localparam int idxBits = oledPkg::pixelIndexBits;
    localparam int panelPixels = oledPkg::panelWidth * oledPkg::panelHeight;
    localparam int moveCount = 40;
    localparam int confirmRounds = 12;
    localparam int pauseReads = 40;
    localparam int pausePresses = 6;
    localparam int streamLength = 64;
    localparam int pressCycles = 29;                          // 1 + 8 high + 20 low
    localparam int readCycles = oledPkg::renderLatency + 2;
    localparam int budgetCycles = 10 + 8 * readCycles
        + moveCount * (pressCycles + 2 * readCycles)
        + confirmRounds * (4 * pressCycles + 2 * readCycles)
        + pauseReads * readCycles + (pausePresses + 1) * pressCycles
        + 2 * readCycles + streamLength + 8;

    logic               clk;
    logic               arstN;
    logic               btnL;
    logic               btnR;
    logic               btnC;
    logic               pause;
    logic [idxBits-1:0] pixelIndex;
    logic [15:0]        oledData;
    logic               restartReq;
    logic               quitReq;

    logic [31:0] lcgState = 32'h86e8_f239;
    int          modelSel;      // expected cursor as the enum value
    int          restartSeen;   // high cycles of each request
    int          quitSeen;
    int          checkCount;
    int          errorCount;
    int          testErrors;

    tetrisMenuOverlay i_dut (
        .clk        (clk),
        .arstN      (arstN),
        .btnL       (btnL),
        .btnR       (btnR),
        .btnC       (btnC),
        .pause      (pause),
        .pixelIndex (pixelIndex),
        .oledData   (oledData),
        .restartReq (restartReq),
        .quitReq    (quitReq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (budgetCycles + budgetCycles / 4) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    always @(negedge clk) begin
        if (restartReq)
            restartSeen++;
        if (quitReq)
            quitSeen++;
    end

    ////////////////////////////////////////////////////////////////////////////
    // model and helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState >> 8;   // low bits of an LCG repeat quickly
    endfunction

    // random pixel in box band 1 or 2 clear of text and arrows
    function automatic int marginIndex(input int band);
        int row;
        int col;
        col = (band == 1 ? 55 : 70) + int'(nextRand() % 11);
        if (nextRand() % 2 == 0)
            row = 43 + int'(nextRand() % 21);   // rotated x 0..20
        else
            row = int'(nextRand() % 22);        // rotated x 42..63
        return row * oledPkg::panelWidth + col;
    endfunction

    // band lights up only when the cursor sits on it
    function automatic logic [15:0] expectedMargin(input int idx, input int sel);
        int   col;
        logic lit;
        col = idx % oledPkg::panelWidth;
        if (col >= 55 && col <= 65)
            lit = (sel == int'(menuPkg::selYes));
        else
            lit = (sel == int'(menuPkg::selNo));
        return lit ? oledPkg::colourWhite : oledPkg::colourBlack;
    endfunction

    // left for 0 and right otherwise with saturation at both ends
    function automatic int movedSel(input int sel, input int which);
        if (which == 0)
            return (sel > int'(menuPkg::selNone)) ? sel - 1 : sel;
        return (sel < int'(menuPkg::selNo)) ? sel + 1 : sel;
    endfunction

    task automatic reportMismatch(input string msg);
        errorCount++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic checkPixel(input int idx, input logic [15:0] want, input string what);
        @(posedge clk);
        pixelIndex <= idxBits'(idx);
        repeat (oledPkg::renderLatency) @(posedge clk);
        @(negedge clk);
        checkCount++;
        if (oledData !== want)
            reportMismatch($sformatf("%s pixel %0d gave %h, expected %h",
                what, idx, oledData, want));
    endtask

    task automatic checkCursor(input string what);
        int idx;
        idx = marginIndex(1);
        checkPixel(idx, expectedMargin(idx, modelSel), what);
        idx = marginIndex(2);
        checkPixel(idx, expectedMargin(idx, modelSel), what);
    endtask

    // 0 left, 1 right, 2 centre
    task automatic pressButton(input int which);
        @(posedge clk);
        case (which)
            0:       btnL <= 1'b1;
            1:       btnR <= 1'b1;
            default: btnC <= 1'b1;
        endcase
        repeat (8) @(posedge clk);
        btnL <= 1'b0;
        btnR <= 1'b0;
        btnC <= 1'b0;
        repeat (20) @(posedge clk);   // 8 low plus 12 to settle
    endtask

    task automatic finishTest(input string name);
        $display("test %s done, %0d errors", name, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          idx;
        int          which;
        int          restartBefore;
        int          quitBefore;
        int          wantRestart;
        int          wantQuit;
        logic [15:0] want [$];

        arstN = 1'b0;
        btnL = 1'b0;
        btnR = 1'b0;
        btnC = 1'b0;
        pause = 1'b0;
        pixelIndex = '0;
        modelSel = int'(menuPkg::selNo);
        restartSeen = 0;
        quitSeen = 0;
        checkCount = 0;
        errorCount = 0;
        testErrors = 0;
        repeat (10) @(posedge clk);
        arstN <= 1'b1;

        repeat (4) checkCursor("reset");
        checkCount++;
        if (restartSeen != 0 || quitSeen != 0)
            reportMismatch("request raised after reset");
        finishTest("reset");

        for (int i = 0; i < moveCount; i++) begin
            which = int'(nextRand() % 2);
            pressButton(which);
            modelSel = movedSel(modelSel, which);
            checkCursor("move");
        end
        finishTest("move");

        for (int i = 0; i < confirmRounds; i++) begin
            repeat (int'(nextRand() % 3) + 1) begin
                which = int'(nextRand() % 2);
                pressButton(which);
                modelSel = movedSel(modelSel, which);
            end
            restartBefore = restartSeen;
            quitBefore = quitSeen;
            wantRestart = (modelSel == int'(menuPkg::selYes)) ? 1 : 0;
            wantQuit = (modelSel == int'(menuPkg::selNo)) ? 1 : 0;
            pressButton(2);
            checkCount++;
            if (restartSeen - restartBefore != wantRestart || quitSeen - quitBefore != wantQuit)
                reportMismatch($sformatf("confirm at cursor %0d gave %0d restart, %0d quit",
                    modelSel, restartSeen - restartBefore, quitSeen - quitBefore));
            modelSel = int'(menuPkg::selNone);
            checkCursor("confirm");
        end
        finishTest("confirm");

        @(posedge clk);
        pause <= 1'b1;
        for (int i = 0; i < pauseReads; i++) begin
            idx = int'(nextRand() % panelPixels);
            // banner columns hold the text and everything else is dark
            if (idx % oledPkg::panelWidth < 45 || idx % oledPkg::panelWidth > 51)
                checkPixel(idx, oledPkg::colourBlack, "pause");
        end
        restartBefore = restartSeen;
        quitBefore = quitSeen;
        repeat (pausePresses) pressButton(int'(nextRand() % 3));
        checkCount++;
        if (restartSeen != restartBefore || quitSeen != quitBefore)
            reportMismatch("request raised while paused");
        @(posedge clk);
        pause <= 1'b0;
        checkCursor("after pause");
        finishTest("pause");

        // cursor onto YES so the two bands differ in colour
        pressButton(1);
        modelSel = movedSel(modelSel, 1);

        // one new index per cycle and the colour lags by the render latency
        for (int i = 0; i < streamLength + oledPkg::renderLatency; i++) begin
            @(posedge clk);
            if (i < streamLength) begin
                idx = marginIndex(1 + int'(nextRand() % 2));
                pixelIndex <= idxBits'(idx);
                want.push_back(expectedMargin(idx, modelSel));
            end
            @(negedge clk);
            if (i >= oledPkg::renderLatency) begin
                checkCount++;
                if (oledData !== want[0])
                    reportMismatch($sformatf("stream item %0d gave %h, expected %h",
                        i - oledPkg::renderLatency, oledData, want[0]));
                void'(want.pop_front());
            end
        end
        finishTest("latency");

        $display("5 tests, %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
